// ==== edge_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

module edge_fifo (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  logic                in_cmd,
	input  place_pkg::in_word_u in_word,
	input  logic                fifo_pop,
	output logic                fifo_valid,
	output logic                fifo_cmd,
	output place_pkg::in_word_u fifo_word,
	output logic                credit_ret
);
	import place_pkg::*;

	// pointers wrap on their own, CREDITS is a power of two
	logic [$clog2(CREDITS)-1:0] wr_ptr;
	logic [$clog2(CREDITS)-1:0] rd_ptr;
	logic [$clog2(CREDITS):0]   count;
	in_word_u                   word_mem [CREDITS];
	logic [CREDITS-1:0]         cmd_mem;
	logic                       pop_ok;

	assign pop_ok     = fifo_pop && fifo_valid;
	assign fifo_valid = (count != '0);
	assign fifo_word  = word_mem[rd_ptr];
	assign fifo_cmd   = cmd_mem[rd_ptr];

	// sender never writes past its credits, so no full check here
	always_ff @(posedge clk) begin
		if (in_valid) begin
			word_mem[wr_ptr] <= in_word;
			cmd_mem[wr_ptr]  <= in_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_ret <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({in_valid, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
			credit_ret <= pop_ok;   // one credit back per word consumed
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
place_pkg.sv
edge_fifo.sv
offset_rom.sv
grid_map.sv
place_fsm.sv
placer_top.sv
tb_clock.sv
placer_chk.sv
tb_top.sv

// ==== grid_map.sv ====
`default_nettype none
`timescale 1ns/1ns

module grid_map (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           clear,
	input  logic [place_pkg::NODE_W-1:0]   rd_a,
	input  logic [place_pkg::NODE_W-1:0]   rd_b,
	output logic                           a_placed,
	output logic [place_pkg::COORD_W-1:0]  a_x,
	output logic [place_pkg::COORD_W-1:0]  a_y,
	output logic                           b_placed,
	output logic [place_pkg::COORD_W-1:0]  b_x,
	output logic [place_pkg::COORD_W-1:0]  b_y,
	input  logic [place_pkg::COORD_W-1:0]  probe_x,
	input  logic [place_pkg::COORD_W-1:0]  probe_y,
	output logic                           probe_busy,
	input  logic                           wr_en,
	input  logic [place_pkg::NODE_W-1:0]   wr_node,
	input  logic [place_pkg::COORD_W-1:0]  wr_x,
	input  logic [place_pkg::COORD_W-1:0]  wr_y
);
	import place_pkg::*;

	logic [GRID_N*GRID_N-1:0] occ;        // cell index is {x, y}
	logic [N_NODES-1:0]       placed;
	logic [COORD_W-1:0]       pos_x [N_NODES];
	logic [COORD_W-1:0]       pos_y [N_NODES];

	// node lookups, valid only where the placed flag is set
	assign a_placed = placed[rd_a];
	assign a_x      = pos_x[rd_a];
	assign a_y      = pos_y[rd_a];
	assign b_placed = placed[rd_b];
	assign b_x      = pos_x[rd_b];
	assign b_y      = pos_y[rd_b];

	assign probe_busy = occ[{probe_x, probe_y}];

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			occ    <= '0;
			placed <= '0;
		end else if (wr_en) begin
			occ[{wr_x, wr_y}] <= 1'b1;
			placed[wr_node]   <= 1'b1;
		end
	end

	// positions are only read behind placed
	always_ff @(posedge clk) begin
		if (wr_en) begin
			pos_x[wr_node] <= wr_x;
			pos_y[wr_node] <= wr_y;
		end
	end

endmodule

`default_nettype wire

// ==== offset_rom.sv ====
`default_nettype none
`timescale 1ns/1ns

module offset_rom (
	input  logic [place_pkg::STEP_W-1:0]       step,
	output logic signed [place_pkg::OFS_W-1:0] dx,
	output logic signed [place_pkg::OFS_W-1:0] dy
);
	import place_pkg::*;

	// fixed greedy search order, nearest cells first
	always_comb begin
		case (step)
			// unit neighbours
			5'd0:  {dx, dy} = {4'sd0, 4'sd1};
			5'd1:  {dx, dy} = {4'sd1, 4'sd0};
			5'd2:  {dx, dy} = {4'sd0, -4'sd1};
			5'd3:  {dx, dy} = {-4'sd1, 4'sd0};
			// diagonals
			5'd4:  {dx, dy} = {-4'sd1, 4'sd1};
			5'd5:  {dx, dy} = {4'sd1, 4'sd1};
			5'd6:  {dx, dy} = {4'sd1, -4'sd1};
			5'd7:  {dx, dy} = {-4'sd1, -4'sd1};
			// two away on an axis
			5'd8:  {dx, dy} = {4'sd0, 4'sd2};
			5'd9:  {dx, dy} = {4'sd2, 4'sd0};
			5'd10: {dx, dy} = {4'sd0, -4'sd2};
			5'd11: {dx, dy} = {-4'sd2, 4'sd0};
			// knight moves
			5'd12: {dx, dy} = {-4'sd1, 4'sd2};
			5'd13: {dx, dy} = {4'sd1, 4'sd2};
			5'd14: {dx, dy} = {4'sd1, -4'sd2};
			5'd15: {dx, dy} = {-4'sd1, -4'sd2};
			5'd16: {dx, dy} = {-4'sd2, 4'sd1};
			5'd17: {dx, dy} = {4'sd2, 4'sd1};
			5'd18: {dx, dy} = {4'sd2, -4'sd1};
			5'd19: {dx, dy} = {-4'sd2, -4'sd1};
			// four away, always off a 4x4 grid from its edge
			5'd20: {dx, dy} = {4'sd0, 4'sd4};
			5'd21: {dx, dy} = {4'sd4, 4'sd0};
			5'd22: {dx, dy} = {4'sd0, -4'sd4};
			5'd23: {dx, dy} = {-4'sd4, 4'sd0};
			// long knight moves
			5'd24: {dx, dy} = {4'sd1, 4'sd3};
			5'd25: {dx, dy} = {4'sd1, -4'sd3};
			5'd26: {dx, dy} = {-4'sd1, -4'sd3};
			5'd27: {dx, dy} = {-4'sd1, 4'sd3};
			default: begin   // past the table
				dx = '0;
				dy = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== place_fsm.sv ====
`default_nettype none
`timescale 1ns/1ns

module place_fsm (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                fifo_valid,
	input  logic                                fifo_cmd,
	input  place_pkg::in_word_u                 fifo_word,
	output logic                                fifo_pop,
	output logic [place_pkg::STEP_W-1:0]        step,
	input  logic signed [place_pkg::OFS_W-1:0]  dx,
	input  logic signed [place_pkg::OFS_W-1:0]  dy,
	output logic                                clear,
	output logic [place_pkg::NODE_W-1:0]        rd_a,
	output logic [place_pkg::NODE_W-1:0]        rd_b,
	input  logic                                a_placed,
	input  logic [place_pkg::COORD_W-1:0]       a_x,
	input  logic [place_pkg::COORD_W-1:0]       a_y,
	input  logic                                b_placed,
	input  logic [place_pkg::COORD_W-1:0]       b_x,
	input  logic [place_pkg::COORD_W-1:0]       b_y,
	output logic [place_pkg::COORD_W-1:0]       probe_x,
	output logic [place_pkg::COORD_W-1:0]       probe_y,
	input  logic                                probe_busy,
	output logic                                wr_en,
	output logic [place_pkg::NODE_W-1:0]        wr_node,
	output logic [place_pkg::COORD_W-1:0]       wr_x,
	output logic [place_pkg::COORD_W-1:0]       wr_y,
	output logic                                res_valid,
	output logic [place_pkg::NODE_W-1:0]        res_node,
	output logic [place_pkg::COORD_W-1:0]       res_x,
	output logic [place_pkg::COORD_W-1:0]       res_y,
	output logic [place_pkg::COST_W-1:0]        cost,
	output logic                                done,
	output logic                                fail
);
	import place_pkg::*;

	logic [2:0]               state;
	logic [NODE_W-1:0]        src_q;
	logic [NODE_W-1:0]        dst_q;        // also holds the start node
	logic                     start_pend;   // start node write due
	logic                     is_start;
	logic                     is_finish;
	logic                     is_edge;
	logic signed [OFS_W:0]    cand_x;
	logic signed [OFS_W:0]    cand_y;
	logic                     in_bounds;
	logic                     hit;
	logic [OFS_W-1:0]         abs_dx;
	logic [OFS_W-1:0]         abs_dy;
	logic [OFS_W:0]           hop_dist;
	logic [COORD_W-1:0]       dist_x;
	logic [COORD_W-1:0]       dist_y;
	logic [COORD_W:0]         link_dist;

	// words are taken only while waiting, failed or finished
	assign fifo_pop = fifo_valid &&
		(state == ST_IDLE || state == ST_FAILED || state == ST_FINISHED);
	assign is_start  = fifo_pop && fifo_cmd && (fifo_word.cmd.op == OP_START);
	assign is_finish = fifo_pop && fifo_cmd && (fifo_word.cmd.op == OP_FINISH) &&
		(state == ST_IDLE);
	assign is_edge   = fifo_pop && !fifo_cmd && (state == ST_IDLE);
	assign clear     = is_start;

	assign rd_a = src_q;
	assign rd_b = dst_q;

	// src position plus offset, widened so negatives stay visible
	assign cand_x = $signed({{(OFS_W + 1 - COORD_W){1'b0}}, a_x}) + dx;
	assign cand_y = $signed({{(OFS_W + 1 - COORD_W){1'b0}}, a_y}) + dy;
	assign in_bounds = (cand_x >= 0) && (cand_x < GRID_N) &&
		(cand_y >= 0) && (cand_y < GRID_N);
	assign probe_x = cand_x[COORD_W-1:0];
	assign probe_y = cand_y[COORD_W-1:0];
	assign hit     = (state == ST_SEARCH) && in_bounds && !probe_busy;

	// a new placement sits exactly one offset away from src
	assign abs_dx   = dx[OFS_W-1] ? -dx : dx;
	assign abs_dy   = dy[OFS_W-1] ? -dy : dy;
	assign hop_dist = {1'b0, abs_dx} + {1'b0, abs_dy};

	// both ends already placed
	assign dist_x    = (a_x > b_x) ? a_x - b_x : b_x - a_x;
	assign dist_y    = (a_y > b_y) ? a_y - b_y : b_y - a_y;
	assign link_dist = {1'b0, dist_x} + {1'b0, dist_y};

	assign wr_en   = start_pend || hit;   // never both in one cycle
	assign wr_node = dst_q;
	assign wr_x    = start_pend ? '0 : probe_x;
	assign wr_y    = start_pend ? '0 : probe_y;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ST_IDLE;
			step       <= '0;
			start_pend <= 1'b0;
			res_valid  <= 1'b0;
			cost       <= '0;
			done       <= 1'b0;
			fail       <= 1'b0;
		end else begin
			start_pend <= is_start;
			res_valid  <= is_start || hit;
			if (is_start) begin   // any state that pops can restart
				state <= ST_IDLE;
				cost  <= '0;
				done  <= 1'b0;
				fail  <= 1'b0;
			end else begin
				case (state)
					ST_IDLE: begin
						if (is_edge) begin
							state <= ST_LOOKUP;
						end else if (is_finish) begin
							done  <= 1'b1;
							state <= ST_FINISHED;
						end
					end
					ST_LOOKUP: begin
						if (!a_placed) begin
							fail  <= 1'b1;
							state <= ST_FAILED;
						end else if (b_placed) begin
							cost  <= cost + COST_W'(link_dist);
							state <= ST_IDLE;
						end else begin
							step  <= '0;
							state <= ST_SEARCH;
						end
					end
					ST_SEARCH: begin
						if (hit) begin
							cost  <= cost + COST_W'(hop_dist);
							state <= ST_IDLE;
						end else if (step == STEP_W'(N_OFFSETS - 1)) begin
							fail  <= 1'b1;   // table exhausted
							state <= ST_FAILED;
						end else begin
							step <= step + 1'b1;
						end
					end
					default: state <= state;   // drain words until a start
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (is_edge) begin
			src_q <= fifo_word.link.src;
			dst_q <= fifo_word.link.dst;
		end else if (is_start) begin
			dst_q <= fifo_word.cmd.node;
		end
		if (is_start) begin   // start node always lands on (0,0)
			res_node <= fifo_word.cmd.node;
			res_x    <= '0;
			res_y    <= '0;
		end else if (hit) begin
			res_node <= dst_q;
			res_x    <= probe_x;
			res_y    <= probe_y;
		end
	end

endmodule

`default_nettype wire

// ==== place_pkg.sv ====
`default_nettype none

package place_pkg;

	localparam int GRID_N    = 4;   // cells per side
	localparam int COORD_W   = 2;
	localparam int NODE_W    = 4;
	localparam int N_NODES   = 16;
	localparam int N_OFFSETS = 28;
	localparam int OFS_W     = 4;   // signed, holds -4..4
	localparam int STEP_W    = 5;
	localparam int CREDITS   = 4;   // buffer depth = sender's starting credits
	localparam int COST_W    = 10;

	localparam logic [1:0] OP_START  = 2'd1;
	localparam logic [1:0] OP_FINISH = 2'd2;

	// placement controller states
	localparam logic [2:0] ST_IDLE     = 3'd0;
	localparam logic [2:0] ST_LOOKUP   = 3'd1;
	localparam logic [2:0] ST_SEARCH   = 3'd2;
	localparam logic [2:0] ST_FAILED   = 3'd3;
	localparam logic [2:0] ST_FINISHED = 3'd4;

	// one input word, read as an edge or as a command depending on in_cmd
	typedef union packed {
		struct packed {
			logic [NODE_W-1:0] src;
			logic [NODE_W-1:0] dst;
		} link;
		struct packed {
			logic [1:0]        op;
			logic              pad_hi;
			logic [NODE_W-1:0] node;   // start node
			logic              pad_lo;
		} cmd;
	} in_word_u;

endpackage

`default_nettype wire

// ==== placer_chk.sv ====
`default_nettype none
`timescale 1ns/1ns

module placer_chk (
	input logic                                  clk,
	input logic                                  rst,
	input logic                                  credit_ret,
	input logic                                  res_valid,
	input logic [place_pkg::NODE_W-1:0]          res_node,
	input logic [place_pkg::COORD_W-1:0]         res_x,
	input logic [place_pkg::COORD_W-1:0]         res_y,
	input logic [place_pkg::COST_W-1:0]          cost,
	input logic                                  done,
	input logic                                  fail,
	input logic [$clog2(place_pkg::CREDITS):0]   fifo_count,
	input int                                    outstanding,
	input logic                                  exp_avail,
	input logic [place_pkg::NODE_W-1:0]          exp_node,
	input logic [place_pkg::COORD_W-1:0]         exp_x,
	input logic [place_pkg::COORD_W-1:0]         exp_y,
	input logic                                  exp_start,
	input logic [15:0]                           seen,
	input logic                                  done_avail,
	input logic [place_pkg::COST_W-1:0]          exp_cost,
	input logic                                  fail_pend
);
	import place_pkg::*;

	int err_cnt = 0;   // read by the testbench top

	// words held or just popped must equal the credits still out
	a_credit_count: assert property (@(posedge clk) disable iff (rst)
		outstanding == int'(fifo_count) + int'(credit_ret))
		else begin
			err_cnt++;
			$error("MISMATCH fifo_count got %h exp %h", $sampled(fifo_count),
				$sampled(outstanding) - int'($sampled(credit_ret)));
		end

	a_credit_ret: assert property (@(posedge clk) disable iff (rst)
		credit_ret |-> outstanding > 0)
		else begin err_cnt++; $error("credit returned with no word outstanding"); end

	a_res_expected: assert property (@(posedge clk) disable iff (rst) res_valid |-> exp_avail)
		else begin err_cnt++; $error("placement reported that the model did not expect"); end

	a_res_node: assert property (@(posedge clk) disable iff (rst)
		res_valid && exp_avail |-> res_node == exp_node)
		else begin
			err_cnt++;
			$error("MISMATCH res_node got %h exp %h", $sampled(res_node), $sampled(exp_node));
		end

	a_res_x: assert property (@(posedge clk) disable iff (rst)
		res_valid && exp_avail |-> res_x == exp_x)
		else begin
			err_cnt++;
			$error("MISMATCH res_x got %h exp %h", $sampled(res_x), $sampled(exp_x));
		end

	a_res_y: assert property (@(posedge clk) disable iff (rst)
		res_valid && exp_avail |-> res_y == exp_y)
		else begin
			err_cnt++;
			$error("MISMATCH res_y got %h exp %h", $sampled(res_y), $sampled(exp_y));
		end

	// cells since the last start must all differ
	a_unique: assert property (@(posedge clk) disable iff (rst)
		res_valid && !exp_start |-> !seen[{res_x, res_y}])
		else begin err_cnt++; $error("cell reported twice since the last start"); end

	a_quiet_fail: assert property (@(posedge clk) disable iff (rst) res_valid |-> !fail)
		else begin err_cnt++; $error("placement reported while failed"); end

	a_cost: assert property (@(posedge clk) disable iff (rst)
		$rose(done) |-> done_avail && cost == exp_cost)
		else begin
			err_cnt++;
			$error("MISMATCH cost got %h exp %h", $sampled(cost), $sampled(exp_cost));
		end

	a_fail: assert property (@(posedge clk) disable iff (rst)
		$rose(fail) |-> fail_pend)
		else begin err_cnt++; $error("fail rose where the model expects no failure"); end

endmodule

`default_nettype wire

// ==== placer_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module placer_top (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           in_valid,
	input  logic                           in_cmd,
	input  place_pkg::in_word_u            in_word,
	output logic                           credit_ret,
	output logic                           res_valid,
	output logic [place_pkg::NODE_W-1:0]   res_node,
	output logic [place_pkg::COORD_W-1:0]  res_x,
	output logic [place_pkg::COORD_W-1:0]  res_y,
	output logic [place_pkg::COST_W-1:0]   cost,
	output logic                           done,
	output logic                           fail
);
	import place_pkg::*;

	// buffer to controller
	logic                     fifo_valid;
	logic                     fifo_cmd;
	in_word_u                 fifo_word;
	logic                     fifo_pop;
	// offset table
	logic [STEP_W-1:0]        step;
	logic signed [OFS_W-1:0]  dx;
	logic signed [OFS_W-1:0]  dy;
	// grid state
	logic                     clear;
	logic [NODE_W-1:0]        rd_a;
	logic [NODE_W-1:0]        rd_b;
	logic                     a_placed;
	logic [COORD_W-1:0]       a_x;
	logic [COORD_W-1:0]       a_y;
	logic                     b_placed;
	logic [COORD_W-1:0]       b_x;
	logic [COORD_W-1:0]       b_y;
	logic [COORD_W-1:0]       probe_x;
	logic [COORD_W-1:0]       probe_y;
	logic                     probe_busy;
	logic                     wr_en;
	logic [NODE_W-1:0]        wr_node;
	logic [COORD_W-1:0]       wr_x;
	logic [COORD_W-1:0]       wr_y;

	edge_fifo u_fifo (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_cmd(in_cmd), .in_word(in_word),
		.fifo_pop(fifo_pop), .fifo_valid(fifo_valid), .fifo_cmd(fifo_cmd),
		.fifo_word(fifo_word), .credit_ret(credit_ret)
	);

	offset_rom u_rom (.step(step), .dx(dx), .dy(dy));

	grid_map u_grid (
		.clk(clk), .rst(rst), .clear(clear), .rd_a(rd_a), .rd_b(rd_b),
		.a_placed(a_placed), .a_x(a_x), .a_y(a_y),
		.b_placed(b_placed), .b_x(b_x), .b_y(b_y),
		.probe_x(probe_x), .probe_y(probe_y), .probe_busy(probe_busy),
		.wr_en(wr_en), .wr_node(wr_node), .wr_x(wr_x), .wr_y(wr_y)
	);

	place_fsm u_fsm (
		.clk(clk), .rst(rst), .fifo_valid(fifo_valid), .fifo_cmd(fifo_cmd),
		.fifo_word(fifo_word), .fifo_pop(fifo_pop), .step(step), .dx(dx), .dy(dy),
		.clear(clear), .rd_a(rd_a), .rd_b(rd_b),
		.a_placed(a_placed), .a_x(a_x), .a_y(a_y),
		.b_placed(b_placed), .b_x(b_x), .b_y(b_y),
		.probe_x(probe_x), .probe_y(probe_y), .probe_busy(probe_busy),
		.wr_en(wr_en), .wr_node(wr_node), .wr_x(wr_x), .wr_y(wr_y),
		.res_valid(res_valid), .res_node(res_node), .res_x(res_x), .res_y(res_y),
		.cost(cost), .done(done), .fail(fail)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the placer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$out"

if [ $status -eq 0 ] && echo "$out" | grep -q "All checks passed"; then
	exit 0
fi
exit 1

// ==== tb_clock.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #4 clk = ~clk;   // 8 ns period

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_top;
	import place_pkg::*;

	logic                clk;
	logic                rst;
	logic                in_valid;
	logic                in_cmd;
	in_word_u            in_word;
	logic                credit_ret;
	logic                res_valid;
	logic [NODE_W-1:0]   res_node;
	logic [COORD_W-1:0]  res_x;
	logic [COORD_W-1:0]  res_y;
	logic [COST_W-1:0]   cost;
	logic                done;
	logic                fail;

	// model state
	int ox [N_OFFSETS] = '{0, 1, 0, -1, -1, 1, 1, -1, 0, 2, 0, -2, -1, 1,
		1, -1, -2, 2, 2, -2, 0, 4, 0, -4, 1, 1, -1, -1};
	int oy [N_OFFSETS] = '{1, 0, -1, 0, 1, 1, -1, -1, 2, 0, -2, 0, 2, 2,
		-2, -2, 1, 1, -1, -1, 4, 0, -4, 0, 3, -3, -3, 3};
	bit m_placed [N_NODES];
	int m_x [N_NODES];
	int m_y [N_NODES];
	bit m_occ [GRID_N][GRID_N];
	bit m_failed;
	int m_cost;

	// expected results queued by the model
	logic [NODE_W-1:0]  r_node [64];
	logic [COORD_W-1:0] r_x [64];
	logic [COORD_W-1:0] r_y [64];
	logic               r_start [64];
	logic [COST_W-1:0]  d_cost [16];
	int f_at [16];   // results due before each failure
	int res_wr = 0;
	int res_rd = 0;
	int done_wr = 0;
	int done_rd = 0;
	int fail_exp = 0;
	int fail_seen = 0;
	int outstanding = 0;
	int n_sent = 0;
	int cycles = 0;
	logic [15:0] seen;
	logic done_q;
	logic fail_q;

	logic               exp_avail;
	logic [NODE_W-1:0]  exp_node;
	logic [COORD_W-1:0] exp_x;
	logic [COORD_W-1:0] exp_y;
	logic               exp_start;
	logic               done_avail;
	logic [COST_W-1:0]  exp_cost;
	logic               fail_pend;

	assign exp_avail  = res_rd < res_wr;
	assign exp_node   = r_node[res_rd % 64];
	assign exp_x      = r_x[res_rd % 64];
	assign exp_y      = r_y[res_rd % 64];
	assign exp_start  = r_start[res_rd % 64];
	assign done_avail = done_rd < done_wr;
	assign exp_cost   = d_cost[done_rd % 16];
	assign fail_pend  = (fail_seen < fail_exp) && (res_rd == f_at[fail_seen % 16]);

	tb_clock clk_gen (.clk(clk));

	placer_top dut0 (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_cmd(in_cmd), .in_word(in_word),
		.credit_ret(credit_ret), .res_valid(res_valid), .res_node(res_node),
		.res_x(res_x), .res_y(res_y), .cost(cost), .done(done), .fail(fail)
	);

	bind placer_top placer_chk chk0 (
		.*, .fifo_count(u_fifo.count), .outstanding(tb_top.outstanding),
		.exp_avail(tb_top.exp_avail),
		.exp_node(tb_top.exp_node), .exp_x(tb_top.exp_x), .exp_y(tb_top.exp_y),
		.exp_start(tb_top.exp_start), .seen(tb_top.seen),
		.done_avail(tb_top.done_avail), .exp_cost(tb_top.exp_cost),
		.fail_pend(tb_top.fail_pend)
	);

	// bookkeeping of credits and of what the DUT has reported
	always @(posedge clk) begin
		if (rst) begin
			outstanding <= 0;
			seen        <= '0;
			done_q      <= 1'b0;
			fail_q      <= 1'b0;
		end else begin
			outstanding <= outstanding + int'(in_valid) - int'(credit_ret);
			done_q      <= done;
			fail_q      <= fail;
			if (res_valid) begin
				if (exp_start)
					seen <= 16'h1;   // start node sits on cell 0
				else
					seen <= seen | (16'h1 << {res_x, res_y});
				res_rd <= res_rd + 1;
			end
			if (done && !done_q)
				done_rd <= done_rd + 1;
			if (fail && !fail_q)
				fail_seen <= fail_seen + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > 40 * n_sent + 200) begin
			$display("timeout: DUT stopped making progress");
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	end

	always @(negedge clk) begin
		if (dut0.chk0.err_cnt != 0) begin
			$display("Checks failed");
			$fatal(1, "assertion failure");
		end
	end

	task automatic push_result(input int node, input int x, input int y, input bit start);
		r_node[res_wr % 64]  = NODE_W'(node);
		r_x[res_wr % 64]     = COORD_W'(x);
		r_y[res_wr % 64]     = COORD_W'(y);
		r_start[res_wr % 64] = start;
		res_wr++;
	endtask

	task automatic expect_failure();
		m_failed = 1;
		f_at[fail_exp % 16] = res_wr;
		fail_exp++;
	endtask

	task automatic send_word(input logic cmd, input logic [7:0] w);
		int idle;
		idle = $urandom % 3;
		repeat (idle) @(negedge clk);
		while (outstanding >= CREDITS)
			@(negedge clk);
		in_valid = 1'b1;
		in_cmd   = cmd;
		in_word  = w;
		n_sent++;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic start_graph(input int n);
		foreach (m_placed[i])
			m_placed[i] = 0;
		foreach (m_occ[i, j])
			m_occ[i][j] = 0;
		m_placed[n] = 1;
		m_x[n] = 0;
		m_y[n] = 0;
		m_occ[0][0] = 1;
		m_failed = 0;
		m_cost = 0;
		push_result(n, 0, 0, 1);
		send_word(1'b1, {OP_START, 1'b0, 4'(n), 1'b0});
	endtask

	task automatic add_edge(input int s, input int d);
		int cx;
		int cy;
		bit found;
		if (!m_failed) begin
			if (!m_placed[s]) begin
				expect_failure();   // unplaced src
			end else if (m_placed[d]) begin
				m_cost += ((m_x[s] > m_x[d]) ? m_x[s] - m_x[d] : m_x[d] - m_x[s]) +
					((m_y[s] > m_y[d]) ? m_y[s] - m_y[d] : m_y[d] - m_y[s]);
			end else begin
				found = 0;
				for (int k = 0; k < N_OFFSETS && !found; k++) begin
					cx = m_x[s] + ox[k];
					cy = m_y[s] + oy[k];
					if (cx >= 0 && cx < GRID_N && cy >= 0 && cy < GRID_N &&
							!m_occ[cx][cy]) begin
						found = 1;
						m_occ[cx][cy] = 1;
						m_placed[d] = 1;
						m_x[d] = cx;
						m_y[d] = cy;
						m_cost += ((cx > m_x[s]) ? cx - m_x[s] : m_x[s] - cx) +
							((cy > m_y[s]) ? cy - m_y[s] : m_y[s] - cy);
						push_result(d, cx, cy, 0);
					end
				end
				if (!found)
					expect_failure();   // offsets exhausted
			end
		end
		send_word(1'b0, {4'(s), 4'(d)});
	endtask

	task automatic finish_graph();
		if (!m_failed) begin
			d_cost[done_wr % 16] = COST_W'(m_cost);
			done_wr++;
		end
		send_word(1'b1, {OP_FINISH, 6'b0});
	endtask

	initial begin
		void'($urandom(5));
		rst      = 1'b1;
		in_valid = 1'b0;
		in_cmd   = 1'b0;
		in_word  = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		// 14 nodes, 15 edges
		start_graph(0);
		add_edge(0, 1);
		add_edge(0, 2);
		add_edge(1, 3);
		add_edge(1, 4);
		add_edge(2, 5);
		add_edge(2, 6);
		add_edge(3, 7);
		add_edge(4, 8);
		add_edge(5, 9);
		add_edge(6, 10);
		add_edge(7, 11);
		add_edge(8, 12);
		add_edge(9, 13);
		add_edge(3, 4);
		add_edge(10, 13);
		finish_graph();

		// src never placed then the rest drained
		start_graph(0);
		add_edge(0, 1);
		add_edge(5, 2);
		add_edge(1, 3);
		finish_graph();

		// only 8 cells reachable from (0,0)
		start_graph(0);
		for (int i = 1; i <= 9; i++)
			add_edge(0, i);
		finish_graph();

		// restart and a random graph
		start_graph(3);
		add_edge(3, 7);
		add_edge(7, 3);
		finish_graph();
		start_graph(0);
		for (int i = 0; i < 12; i++)
			add_edge($urandom % 4, $urandom % 16);
		finish_graph();

		while (!(outstanding == 0 && res_rd == res_wr && done_rd == done_wr &&
				fail_seen == fail_exp))
			@(negedge clk);
		repeat (4) @(negedge clk);
		if (dut0.chk0.err_cnt == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "assertion failure");
		end
	end

endmodule

`default_nettype wire
